/* verif/mem_patterns.txt */
# test op size(0 b,1 h,2 w,3 d) unsigned addr(hex) wdata(hex) rd expected(hex) misalign wait
# wait 1 drains all results before the next line, 0 issues the next line on the next cycle
1 store 3 0 100 0123456789abcdef 0 0 0 1
1 load  3 0 100 0 5 0123456789abcdef 0 1
2 store 3 0 200 8877665544332211 0 0 0 1
2 store 0 0 203 ffffffffffffffa5 0 0 0 1
2 store 1 0 206 deadbeefcafebeef 0 0 0 1
2 load  3 0 200 0 6 beef6655a5332211 0 1
3 store 3 0 300 8e7125d9f04ba3c6 0 0 0 1
3 load  0 0 300 0 1 ffffffffffffffc6 0 1
3 load  0 0 301 0 2 ffffffffffffffa3 0 1
3 load  0 0 302 0 3 000000000000004b 0 1
3 load  0 0 303 0 4 fffffffffffffff0 0 1
3 load  0 0 304 0 5 ffffffffffffffd9 0 1
3 load  0 0 305 0 6 0000000000000025 0 1
3 load  0 0 306 0 7 0000000000000071 0 1
3 load  0 0 307 0 8 ffffffffffffff8e 0 1
3 load  0 1 301 0 9 00000000000000a3 0 1
3 load  0 1 307 0 10 000000000000008e 0 1
3 load  1 0 300 0 11 ffffffffffffa3c6 0 1
3 load  1 0 302 0 12 fffffffffffff04b 0 1
3 load  1 0 304 0 13 00000000000025d9 0 1
3 load  1 0 306 0 14 ffffffffffff8e71 0 1
3 load  1 1 306 0 15 0000000000008e71 0 1
3 load  2 0 300 0 16 fffffffff04ba3c6 0 1
3 load  2 0 304 0 17 ffffffff8e7125d9 0 1
3 load  2 1 304 0 18 000000008e7125d9 0 1
3 load  3 0 300 0 19 8e7125d9f04ba3c6 0 1
4 store 3 0 400 0011223344556677 0 0 0 1
4 store 1 0 401 ffffffffffffffff 0 0 1 1
4 load  2 0 402 0 7 0 1 1
4 store 3 0 404 ffffffffffffffff 0 0 1 1
4 load  3 0 400 0 8 0011223344556677 0 1
5 store 3 0 500 a1b2c3d4e5f60718 0 0 0 0
5 load  3 0 500 0 9 a1b2c3d4e5f60718 0 0
5 store 2 0 504 00000000cafef00d 0 0 0 0
5 load  3 0 500 0 10 cafef00de5f60718 0 0
5 load  0 1 507 0 11 00000000000000ca 0 1

/* all.f */
design/lsu_pkg.sv
design/mem_req_latch.sv
design/lsu.sv
design/data_ram.sv
design/wb_reg.sv
design/mem_stage_top.sv
verif/tb_clock.sv
verif/mem_stage_asserts.sv
verif/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module mem_stage_tb -f all.f \
  && { ./obj_dir/Vmem_stage_tb > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -q -e "Finished with errors" -e "%Error" sim.log \
  && grep -q "Finished with no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/mem_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

  import lsu_pkg::*;

  localparam int WAIT_LIMIT = 10;

  logic      clk;
  logic      reset;
  logic      req;
  logic      is_store;
  mem_size_t size;
  logic      uns;
  xlen_t     addr;
  xlen_t     wdata;
  reg_addr_t rd;
  logic      wb_valid;
  reg_addr_t wb_rd;
  xlen_t     wb_data;
  logic      misalign;

  int cycle = 0;
  int checks = 0;
  int errors = 0;

  // outstanding expectations, oldest first
  int        ld_cycle_q[$];
  xlen_t     ld_data_q[$];
  reg_addr_t ld_rd_q[$];
  int        mis_cycle_q[$];

  tb_clock #(.PERIOD_NS(8)) u_clock (.clk_o(clk));

  mem_stage_top #(
    .RAM_AW (RAM_AW_DEFAULT)
  ) dut (
    .clk_i      (clk),
    .reset_i    (reset),
    .req_i      (req),
    .is_store_i (is_store),
    .size_i     (size),
    .unsigned_i (uns),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .rd_i       (rd),
    .wb_valid_o (wb_valid),
    .wb_rd_o    (wb_rd),
    .wb_data_o  (wb_data),
    .misalign_o (misalign)
  );

  bind lsu mem_stage_asserts u_asserts (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ram_we_i   (ram_we_o),
    .ram_re_i   (ram_re_o),
    .ram_mask_i (ram_mask_o),
    .misalign_i (misalign_o)
  );

  // edge count, a request driven now is sampled at cycle + 1
  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_data(input xlen_t got, input xlen_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rd(input reg_addr_t got, input reg_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input int t, inout int c0, inout int e0);
    $display("test %0d done: %0d checks, %0d errors", t, checks - c0, errors - e0);
    c0 = checks;
    e0 = errors;
  endtask

  // wait for all expected results, then a quiet window after a fault
  task automatic drain(input bit had_mis, output bit ok);
    int n;
    n = 0;
    while ((ld_cycle_q.size() != 0 || mis_cycle_q.size() != 0) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    ok = (ld_cycle_q.size() == 0 && mis_cycle_q.size() == 0);
    if (!ok) begin
      errors++;
      if (ld_cycle_q.size() != 0) begin
        $display("timeout at %0t: write-back never came for load to x%0d", $time, ld_rd_q[0]);
      end else begin
        $display("timeout at %0t: misalign strobe never came", $time);
      end
    end else if (had_mis) begin
      while (n < WAIT_LIMIT) begin
        next_cycle();
        n++;
      end
    end
  endtask

  // outputs sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    logic exp_mis;
    if (!reset) begin
      if (wb_valid) begin
        if (ld_cycle_q.size() == 0) begin
          errors++;
          $display("error at %0t: write-back to x%0d with no load outstanding", $time, wb_rd);
        end else begin
          checks++;
          if (cycle != ld_cycle_q[0] + 2) begin
            errors++;
            $display("error at %0t: write-back at cycle %0d, expected cycle %0d",
                     $time, cycle, ld_cycle_q[0] + 2);
          end
          check_data(wb_data, ld_data_q[0], "wb_data_o");
          check_rd(wb_rd, ld_rd_q[0], "wb_rd_o");
          void'(ld_cycle_q.pop_front());
          void'(ld_data_q.pop_front());
          void'(ld_rd_q.pop_front());
        end
      end
      exp_mis = (mis_cycle_q.size() != 0) && (mis_cycle_q[0] + 1 == cycle);
      if (misalign || exp_mis) begin
        check_flag(misalign, exp_mis, "misalign_o");
        if (exp_mis) void'(mis_cycle_q.pop_front());
      end
    end
  end

  initial begin
    int          fd;
    int          n_read;
    int          t;
    int          cur_test;
    int          size_v;
    int          uns_v;
    int          rd_v;
    int          mis_v;
    int          wait_v;
    int          c0;
    int          e0;
    logic [39:0] op_txt;
    xlen_t       addr_v;
    xlen_t       wdata_v;
    xlen_t       exp_v;
    string       line;
    bit          ok;
    bit          had_mis;
    bit          abort;

    reset    = 1'b1;
    req      = 1'b0;
    is_store = 1'b0;
    size     = SIZE_B;
    uns      = 1'b0;
    addr     = '0;
    wdata    = '0;
    rd       = '0;
    cur_test = 0;
    had_mis  = 1'b0;
    abort    = 1'b0;
    c0       = 0;
    e0       = 0;

    // strobes stay low through reset and the cycle after
    repeat (16) begin
      next_cycle();
      check_flag(wb_valid, 1'b0, "wb_valid_o in reset");
      check_flag(misalign, 1'b0, "misalign_o in reset");
    end
    reset = 1'b0;
    next_cycle();
    check_flag(wb_valid, 1'b0, "wb_valid_o after reset");
    check_flag(misalign, 1'b0, "misalign_o after reset");
    report_test(6, c0, e0);

    fd = $fopen("verif/mem_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open verif/mem_patterns.txt");
      abort = 1'b1;
    end
    while (!abort && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      n_read = $sscanf(line, "%d %s %d %d %h %h %d %h %d %d", t, op_txt, size_v, uns_v,
                       addr_v, wdata_v, rd_v, exp_v, mis_v, wait_v);
      if (n_read != 10) continue;
      if (t != cur_test) begin
        if (cur_test != 0) report_test(cur_test, c0, e0);
        cur_test = t;
      end
      req      = 1'b1;
      is_store = (op_txt == "store");
      size     = mem_size_t'(size_v);
      uns      = (uns_v != 0);
      addr     = addr_v;
      wdata    = wdata_v;
      rd       = reg_addr_t'(rd_v);
      if (mis_v != 0) begin
        mis_cycle_q.push_back(cycle + 1);
        had_mis = 1'b1;
      end else if (!is_store) begin
        ld_cycle_q.push_back(cycle + 1);
        ld_data_q.push_back(exp_v);
        ld_rd_q.push_back(reg_addr_t'(rd_v));
      end
      next_cycle();
      if (wait_v != 0) begin
        req = 1'b0;
        drain(had_mis, ok);
        had_mis = 1'b0;
        if (!ok) abort = 1'b1;
      end
    end
    if (fd != 0) $fclose(fd);
    req = 1'b0;
    if (cur_test != 0) report_test(cur_test, c0, e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/mem_stage_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_asserts (
  input wire logic                clk_i,
  input wire logic                reset_i,
  input wire logic                ram_we_i,
  input wire logic                ram_re_i,
  input wire lsu_pkg::byte_mask_t ram_mask_i,
  input wire logic                misalign_i
);

  // one request port, so at most one enable
  one_enable: assert property (
    @(posedge clk_i) disable iff (reset_i) !(ram_we_i && ram_re_i)
  ) else $error("ram write and read enables high together");

  // a store always touches at least one lane
  mask_nonzero: assert property (
    @(posedge clk_i) disable iff (reset_i) ram_we_i |-> (ram_mask_i != '0)
  ) else $error("ram write with an empty byte mask");

  // fault strobe and RAM access never overlap
  no_access_on_fault: assert property (
    @(posedge clk_i) disable iff (reset_i) misalign_i |-> !(ram_we_i || ram_re_i)
  ) else $error("misalign strobe in the same cycle as a ram enable");

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 8
) (
  output logic clk_o
);

  // free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* design/mem_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
  parameter int RAM_AW = lsu_pkg::RAM_AW_DEFAULT
) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               req_i,
  input  wire logic               is_store_i,
  input  wire lsu_pkg::mem_size_t size_i,
  input  wire logic               unsigned_i,
  input  wire lsu_pkg::xlen_t     addr_i,
  input  wire lsu_pkg::xlen_t     wdata_i,
  input  wire lsu_pkg::reg_addr_t rd_i,
  output logic                    wb_valid_o,
  output lsu_pkg::reg_addr_t      wb_rd_o,
  output lsu_pkg::xlen_t          wb_data_o,
  output logic                    misalign_o
);

  import lsu_pkg::*;

  // latched request
  logic        q_valid;
  logic        q_is_store;
  mem_size_t   q_size;
  logic        q_unsigned;
  xlen_t       q_addr;
  xlen_t       q_wdata;
  reg_addr_t   q_rd;

  // RAM side
  logic              ram_we;
  logic              ram_re;
  logic [RAM_AW-1:0] ram_addr;
  xlen_t             ram_wdata;
  byte_mask_t        ram_mask;
  xlen_t             ram_rdata;

  // load result
  logic        ld_valid;
  reg_addr_t   ld_rd;
  xlen_t       ld_data;

  mem_req_latch u_req_latch (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .is_store_i (is_store_i),
    .size_i     (size_i),
    .unsigned_i (unsigned_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .rd_i       (rd_i),
    .valid_o    (q_valid),
    .is_store_o (q_is_store),
    .size_o     (q_size),
    .unsigned_o (q_unsigned),
    .addr_o     (q_addr),
    .wdata_o    (q_wdata),
    .rd_o       (q_rd)
  );

  lsu #(
    .RAM_AW (RAM_AW)
  ) u_lsu (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (q_valid),
    .is_store_i  (q_is_store),
    .size_i      (q_size),
    .unsigned_i  (q_unsigned),
    .addr_i      (q_addr),
    .wdata_i     (q_wdata),
    .rd_i        (q_rd),
    .ram_we_o    (ram_we),
    .ram_re_o    (ram_re),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_mask_o  (ram_mask),
    .ram_rdata_i (ram_rdata),
    .ld_valid_o  (ld_valid),
    .ld_rd_o     (ld_rd),
    .ld_data_o   (ld_data),
    .misalign_o  (misalign_o)
  );

  data_ram #(
    .RAM_AW (RAM_AW)
  ) u_data_ram (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .re_i    (ram_re),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .mask_i  (ram_mask),
    .rdata_o (ram_rdata)
  );

  wb_reg u_wb_reg (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .ld_valid_i (ld_valid),
    .ld_rd_i    (ld_rd),
    .ld_data_i  (ld_data),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

endmodule

`default_nettype wire

/* design/wb_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_reg (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               ld_valid_i,
  input  wire lsu_pkg::reg_addr_t ld_rd_i,
  input  wire lsu_pkg::xlen_t     ld_data_i,
  output logic                    wb_valid_o,
  output lsu_pkg::reg_addr_t      wb_rd_o,
  output lsu_pkg::xlen_t          wb_data_o
);

  import lsu_pkg::*;

  // write-back strobe toward the register file
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= ld_valid_i;
    end
  end

  // result payload, only updated with a load
  always_ff @(posedge clk_i) begin
    if (ld_valid_i) begin
      wb_rd_o   <= ld_rd_i;
      wb_data_o <= ld_data_i;
    end
  end

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
  parameter int RAM_AW = lsu_pkg::RAM_AW_DEFAULT
) (
  input  wire logic                clk_i,
  input  wire logic                we_i,
  input  wire logic                re_i,
  input  wire logic [RAM_AW-1:0]   addr_i,
  input  wire lsu_pkg::xlen_t      wdata_i,
  input  wire lsu_pkg::byte_mask_t mask_i,
  output lsu_pkg::xlen_t           rdata_o
);

  import lsu_pkg::*;

  localparam int DEPTH = 1 << RAM_AW;
  localparam int NBYTES = XLEN / 8;

  xlen_t mem [DEPTH];

  // byte-masked write, one lane at a time
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (mask_i[i]) begin
          mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // registered read port
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu #(
  parameter int RAM_AW = lsu_pkg::RAM_AW_DEFAULT
) (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                valid_i,
  input  wire logic                is_store_i,
  input  wire lsu_pkg::mem_size_t  size_i,
  input  wire logic                unsigned_i,
  input  wire lsu_pkg::xlen_t      addr_i,
  input  wire lsu_pkg::xlen_t      wdata_i,
  input  wire lsu_pkg::reg_addr_t  rd_i,
  output logic                     ram_we_o,
  output logic                     ram_re_o,
  output logic [RAM_AW-1:0]        ram_addr_o,
  output lsu_pkg::xlen_t           ram_wdata_o,
  output lsu_pkg::byte_mask_t      ram_mask_o,
  input  wire lsu_pkg::xlen_t      ram_rdata_i,
  output logic                     ld_valid_o,
  output lsu_pkg::reg_addr_t       ld_rd_o,
  output lsu_pkg::xlen_t           ld_data_o,
  output logic                     misalign_o
);

  import lsu_pkg::*;

  byte_off_t  off;
  logic       misaligned;
  byte_mask_t base_mask;

  // load info for the cycle the RAM data comes back
  logic       ld_valid_q;
  byte_off_t  ld_off_q;
  mem_size_t  ld_size_q;
  logic       ld_uns_q;
  reg_addr_t  ld_rd_q;
  logic       misalign_q;

  xlen_t      lane;
  logic       sign_bit;

  assign off = addr_i[2:0];

  // natural alignment check and size-to-mask decode
  always_comb begin
    case (size_i)
      SIZE_B: begin
        misaligned = 1'b0;
        base_mask  = MASK_B;
      end
      SIZE_H: begin
        misaligned = off[0];
        base_mask  = MASK_H;
      end
      SIZE_W: begin
        misaligned = |off[1:0];
        base_mask  = MASK_W;
      end
      default: begin
        misaligned = |off;
        base_mask  = MASK_D;
      end
    endcase
  end

  // only aligned accesses reach the RAM
  assign ram_we_o    = valid_i & ~misaligned & is_store_i;
  assign ram_re_o    = valid_i & ~misaligned & ~is_store_i;
  assign ram_addr_o  = addr_i[RAM_AW+2:3];
  assign ram_mask_o  = base_mask << off;
  assign ram_wdata_o = wdata_i << {off, 3'b000};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ld_valid_q <= 1'b0;
      misalign_q <= 1'b0;
    end else begin
      ld_valid_q <= ram_re_o;
      misalign_q <= valid_i & misaligned;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ram_re_o) begin
      ld_off_q  <= off;
      ld_size_q <= size_i;
      ld_uns_q  <= unsigned_i;
      ld_rd_q   <= rd_i;
    end
  end

  // bring the addressed lane down to bit 0
  assign lane = ram_rdata_i >> {ld_off_q, 3'b000};

  // sign or zero extend from the top kept bit
  always_comb begin
    case (ld_size_q)
      SIZE_B: begin
        sign_bit  = lane[7] & ~ld_uns_q;
        ld_data_o = {{56{sign_bit}}, lane[7:0]};
      end
      SIZE_H: begin
        sign_bit  = lane[15] & ~ld_uns_q;
        ld_data_o = {{48{sign_bit}}, lane[15:0]};
      end
      SIZE_W: begin
        sign_bit  = lane[31] & ~ld_uns_q;
        ld_data_o = {{32{sign_bit}}, lane[31:0]};
      end
      default: begin
        sign_bit  = 1'b0;
        ld_data_o = lane;
      end
    endcase
  end

  assign ld_valid_o = ld_valid_q;
  assign ld_rd_o    = ld_rd_q;
  assign misalign_o = misalign_q;

endmodule

`default_nettype wire

/* design/mem_req_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_req_latch (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               req_i,
  input  wire logic               is_store_i,
  input  wire lsu_pkg::mem_size_t size_i,
  input  wire logic               unsigned_i,
  input  wire lsu_pkg::xlen_t     addr_i,
  input  wire lsu_pkg::xlen_t     wdata_i,
  input  wire lsu_pkg::reg_addr_t rd_i,
  output logic                    valid_o,
  output logic                    is_store_o,
  output lsu_pkg::mem_size_t      size_o,
  output logic                    unsigned_o,
  output lsu_pkg::xlen_t          addr_o,
  output lsu_pkg::xlen_t          wdata_o,
  output lsu_pkg::reg_addr_t      rd_o
);

  import lsu_pkg::*;

  // strobe only lasts one cycle unless a new request comes in
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
    end
  end

  // request fields, held between requests
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      is_store_o <= is_store_i;
      size_o     <= size_i;
      unsigned_o <= unsigned_i;
      addr_o     <= addr_i;
      wdata_o    <= wdata_i;
      rd_o       <= rd_i;
    end
  end

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // datapath width of the core
  localparam int XLEN = 64;

  // word-address bits of the data RAM unless the top overrides it
  localparam int RAM_AW_DEFAULT = 8;

  // full data word, also used for addresses
  typedef logic [XLEN-1:0] xlen_t;

  // destination register index
  typedef logic [4:0] reg_addr_t;

  // one write-enable bit per byte lane
  typedef logic [XLEN/8-1:0] byte_mask_t;

  // byte position inside a 64-bit word
  typedef logic [2:0] byte_off_t;

  // access size code
  typedef logic [1:0] mem_size_t;

  localparam mem_size_t SIZE_B = 2'd0;
  localparam mem_size_t SIZE_H = 2'd1;
  localparam mem_size_t SIZE_W = 2'd2;
  localparam mem_size_t SIZE_D = 2'd3;

  // base masks before the lane shift
  localparam byte_mask_t MASK_B = 8'h01;
  localparam byte_mask_t MASK_H = 8'h03;
  localparam byte_mask_t MASK_W = 8'h0f;
  localparam byte_mask_t MASK_D = 8'hff;

endpackage

`default_nettype wire
